//--- rtl/icache_consts.svh
// --------------------------------------------------------------------------
// size macros for the direct-mapped instruction cache
// every width in the design derives from this one address split;
// include before any use of the icache types or sizes
// --------------------------------------------------------------------------

`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch byte address
`define IC_ADDR_W   16
// byte offset inside an 8-byte line
`define IC_OFFSET_W 3
// 128 lines
`define IC_INDEX_W  7
// what is left of the address above index and offset
`define IC_TAG_W    (`IC_ADDR_W - `IC_INDEX_W - `IC_OFFSET_W)
// one memory beat, and one full line
`define IC_WORD_W   32
`define IC_DWORD_W  64

`endif

//--- rtl/icache_pkg.sv
// --------------------------------------------------------------------------
// shared types of the instruction cache
// referenced by scoped name from every rtl block
// --------------------------------------------------------------------------

`include "icache_consts.svh"

package icache_pkg;

        // address fields
        typedef logic [`IC_INDEX_W-1:0] ic_index_t;
        typedef logic [`IC_TAG_W-1:0]   ic_tag_t;

        // one memory beat and one whole line, big-endian
        typedef logic [`IC_WORD_W-1:0]  ic_word_t;
        typedef logic [`IC_DWORD_W-1:0] ic_dword_t;

        // controller states, in the order a miss walks through them
        typedef enum logic [2:0] {
                IDLE, LOOKUP, MISS_REQ, FILL_HI, FILL_LO, REPLAY, RESP
        } ic_state_t;

endpackage

//--- rtl/icache_data_ram.sv
// --------------------------------------------------------------------------
// byte-organised data array of the instruction cache
// read returns a whole big-endian doubleword one cycle after rd_en;
// writes land one 32-bit half at a time under a two-bit enable
// --------------------------------------------------------------------------

`include "icache_consts.svh"

module icache_data_ram (
        input  logic                  clk,
        input  icache_pkg::ic_index_t index,
        input  logic                  rd_en,
        input  logic [1:0]            wr_en,
        input  icache_pkg::ic_word_t  wr_data,
        output icache_pkg::ic_dword_t rd_data
);

        localparam int WORD_BYTES  = `IC_WORD_W / 8;
        localparam int DWORD_BYTES = `IC_DWORD_W / 8;
        localparam int NUM_BYTES   = 1 << (`IC_INDEX_W + `IC_OFFSET_W);

        // byte storage, line index on top and byte offset below
        logic [7:0] mem [0:NUM_BYTES-1];

        // bit 1 fills bytes 0-3, bit 0 fills bytes 4-7
        // the first byte of a half takes the top byte of the word
        always_ff @(posedge clk) begin
                if (wr_en[1]) begin
                        for (int b = 0; b < WORD_BYTES; b++) begin
                                mem[{index, `IC_OFFSET_W'(b)}] <=
                                        wr_data[`IC_WORD_W-1-8*b -: 8];
                        end
                end
                if (wr_en[0]) begin
                        for (int b = 0; b < WORD_BYTES; b++) begin
                                mem[{index, `IC_OFFSET_W'(b + WORD_BYTES)}] <=
                                        wr_data[`IC_WORD_W-1-8*b -: 8];
                        end
                end
        end

        // registered read, byte 0 lands in the top byte of rd_data
        // output holds its last value while rd_en is low
        always_ff @(posedge clk) begin
                if (rd_en) begin
                        for (int b = 0; b < DWORD_BYTES; b++) begin
                                rd_data[`IC_DWORD_W-1-8*b -: 8] <=
                                        mem[{index, `IC_OFFSET_W'(b)}];
                        end
                end
        end

        // the controller fills one half per beat, never both at once
        assert property (@(posedge clk) $onehot0(wr_en))
                else $error("Fail %0t: both data array halves written together", $time);

endmodule

//--- rtl/icache_tag_ram.sv
// --------------------------------------------------------------------------
// tag array of the instruction cache, one tag and valid bit per line
// registered read as in the data array; a tag write also marks the line
// valid, and flush clears every valid bit on its edge
// --------------------------------------------------------------------------

`include "icache_consts.svh"

module icache_tag_ram (
        input  logic                  clk,
        input  logic                  arst_n,
        input  icache_pkg::ic_index_t index,
        input  logic                  rd_en,
        input  logic                  tag_wr,
        input  icache_pkg::ic_tag_t   tag_wdata,
        input  logic                  flush,
        output icache_pkg::ic_tag_t   rd_tag,
        output logic                  rd_valid
);

        localparam int NUM_LINES = 1 << `IC_INDEX_W;

        // one tag per line, meaningful only while its valid bit is set
        icache_pkg::ic_tag_t tag_mem [0:NUM_LINES-1];
        logic [NUM_LINES-1:0] valid_q;

        always_ff @(posedge clk) begin
                if (tag_wr) begin
                        tag_mem[index] <= tag_wdata;
                end
        end

        // whole-cache invalidate in one cycle
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        valid_q <= '0;
                end else if (flush) begin
                        valid_q <= '0;
                end else if (tag_wr) begin
                        valid_q[index] <= 1'b1;
                end
        end

        // read side is sampled together with the data array
        always_ff @(posedge clk) begin
                if (rd_en) begin
                        rd_tag <= tag_mem[index];
                end
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        rd_valid <= 1'b0;
                end else if (rd_en) begin
                        rd_valid <= valid_q[index];
                end
        end

        // flush only happens in idle and tag writes only at the end of a fill
        assert property (@(posedge clk) disable iff (!arst_n) !(flush && tag_wr))
                else $error("Fail %0t: flush and tag write on the same edge", $time);

endmodule

//--- rtl/icache_ctrl.sv
// --------------------------------------------------------------------------
// instruction cache controller
// accepts a fetch, looks up tag and data arrays, and on a miss requests
// the line from memory, fills both halves, replays the read and responds.
// a hit answers in the cycle right after acceptance
// --------------------------------------------------------------------------

`include "icache_consts.svh"

module icache_ctrl (
        input  logic                   clk,
        input  logic                   arst_n,
        // fetch request
        input  logic                   req_valid,
        output logic                   req_ready,
        input  logic [`IC_ADDR_W-1:0]  req_addr,
        // fetch response
        output logic                   rsp_valid,
        input  logic                   rsp_ready,
        output icache_pkg::ic_dword_t  rsp_data,
        // memory request
        output logic                   mem_req_valid,
        input  logic                   mem_req_ready,
        output logic [`IC_ADDR_W-1:0]  mem_req_addr,
        // memory response, upper word first
        input  logic                   mem_rsp_valid,
        input  icache_pkg::ic_word_t   mem_rsp_data,
        // flush
        input  logic                   flush_valid,
        output logic                   flush_ready,
        // to the arrays
        output icache_pkg::ic_index_t  index,
        output logic                   rd_en,
        output logic [1:0]             wr_en,
        output icache_pkg::ic_word_t   wr_data,
        output logic                   tag_wr,
        output icache_pkg::ic_tag_t    tag_wdata,
        output logic                   flush,
        // from the arrays
        input  icache_pkg::ic_dword_t  rd_data,
        input  icache_pkg::ic_tag_t    rd_tag,
        input  logic                   rd_valid
);

        icache_pkg::ic_state_t state_q;
        icache_pkg::ic_state_t state_d;

        // accepted address, split into its fields
        icache_pkg::ic_tag_t   tag_q;
        icache_pkg::ic_index_t index_q;

        // fields of the address on the fetch bus right now
        icache_pkg::ic_tag_t   req_tag;
        icache_pkg::ic_index_t req_index;

        // goes high on the first edge after reset release
        logic run_q;
        logic accept;
        logic hit;

        assign req_index = req_addr[`IC_OFFSET_W +: `IC_INDEX_W];
        assign req_tag   = req_addr[`IC_ADDR_W-1 -: `IC_TAG_W];

        // idle is the only state that takes new work
        assign req_ready   = run_q && (state_q == icache_pkg::IDLE);
        assign flush_ready = req_ready;

        // flush wins over a fetch on the same edge
        assign flush  = flush_ready && flush_valid;
        assign accept = req_ready && req_valid && !flush_valid;

        // registered array outputs compared against the held tag
        assign hit = rd_valid && (rd_tag == tag_q);

        // data array output feeds the response directly, it only moves on rd_en
        assign rsp_data = rd_data;

        // fill path and line-aligned miss address
        assign wr_data      = mem_rsp_data;
        assign tag_wdata    = tag_q;
        assign mem_req_addr = {tag_q, index_q, {`IC_OFFSET_W{1'b0}}};

        always_comb begin
                state_d       = state_q;
                index         = index_q;
                rd_en         = 1'b0;
                wr_en         = 2'b00;
                tag_wr        = 1'b0;
                rsp_valid     = 1'b0;
                mem_req_valid = 1'b0;
                case (state_q)
                        icache_pkg::IDLE: begin
                                // arrays read on the accept edge, straight from the bus
                                index = req_index;
                                if (accept) begin
                                        rd_en   = 1'b1;
                                        state_d = icache_pkg::LOOKUP;
                                end
                        end
                        icache_pkg::LOOKUP: begin
                                if (hit) begin
                                        rsp_valid = 1'b1;
                                        // park in RESP while the fetch side stalls
                                        state_d = rsp_ready ? icache_pkg::IDLE
                                                            : icache_pkg::RESP;
                                end else begin
                                        state_d = icache_pkg::MISS_REQ;
                                end
                        end
                        icache_pkg::MISS_REQ: begin
                                mem_req_valid = 1'b1;
                                if (mem_req_ready) begin
                                        state_d = icache_pkg::FILL_HI;
                                end
                        end
                        icache_pkg::FILL_HI: begin
                                // first beat is bytes 0-3 of the line
                                if (mem_rsp_valid) begin
                                        wr_en   = 2'b10;
                                        state_d = icache_pkg::FILL_LO;
                                end
                        end
                        icache_pkg::FILL_LO: begin
                                // second beat completes the line, tag goes in with it
                                if (mem_rsp_valid) begin
                                        wr_en   = 2'b01;
                                        tag_wr  = 1'b1;
                                        state_d = icache_pkg::REPLAY;
                                end
                        end
                        icache_pkg::REPLAY: begin
                                // re-read the freshly filled line
                                rd_en   = 1'b1;
                                state_d = icache_pkg::RESP;
                        end
                        icache_pkg::RESP: begin
                                rsp_valid = 1'b1;
                                if (rsp_ready) begin
                                        state_d = icache_pkg::IDLE;
                                end
                        end
                        default: begin
                                state_d = icache_pkg::IDLE;
                        end
                endcase
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        state_q <= icache_pkg::IDLE;
                        run_q   <= 1'b0;
                end else begin
                        state_q <= state_d;
                        run_q   <= 1'b1;
                end
        end

        // accepted address, held for the whole transaction
        always_ff @(posedge clk) begin
                if (accept) begin
                        tag_q   <= req_tag;
                        index_q <= req_index;
                end
        end

        // a stalled response must not change under the fetch side
        assert property (@(posedge clk) disable iff (!arst_n)
                        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
                else $error("Fail %0t: response changed under back-pressure", $time);

        // memory request is held until memory takes it
        assert property (@(posedge clk) disable iff (!arst_n)
                        mem_req_valid && !mem_req_ready |=> mem_req_valid)
                else $error("Fail %0t: mem_req_valid dropped before mem_req_ready", $time);

endmodule

//--- rtl/icache_top.sv
// --------------------------------------------------------------------------
// instruction cache top level
// joins the controller to the tag and data arrays and brings out the
// fetch, memory and flush handshakes
// --------------------------------------------------------------------------

`include "icache_consts.svh"

module icache_top (
        input  logic                  clk,
        input  logic                  arst_n,
        input  logic                  req_valid,
        output logic                  req_ready,
        input  logic [`IC_ADDR_W-1:0] req_addr,
        output logic                  rsp_valid,
        input  logic                  rsp_ready,
        output icache_pkg::ic_dword_t rsp_data,
        output logic                  mem_req_valid,
        input  logic                  mem_req_ready,
        output logic [`IC_ADDR_W-1:0] mem_req_addr,
        input  logic                  mem_rsp_valid,
        input  icache_pkg::ic_word_t  mem_rsp_data,
        input  logic                  flush_valid,
        output logic                  flush_ready
);

        // shared array address and read strobe
        icache_pkg::ic_index_t index;
        logic                  rd_en;
        // data array
        logic [1:0]            wr_en;
        icache_pkg::ic_word_t  wr_data;
        icache_pkg::ic_dword_t rd_data;
        // tag array
        logic                  tag_wr;
        icache_pkg::ic_tag_t   tag_wdata;
        logic                  flush;
        icache_pkg::ic_tag_t   rd_tag;
        logic                  rd_valid;

        icache_ctrl u_ctrl (
                .clk           (clk),
                .arst_n        (arst_n),
                .req_valid     (req_valid),
                .req_ready     (req_ready),
                .req_addr      (req_addr),
                .rsp_valid     (rsp_valid),
                .rsp_ready     (rsp_ready),
                .rsp_data      (rsp_data),
                .mem_req_valid (mem_req_valid),
                .mem_req_ready (mem_req_ready),
                .mem_req_addr  (mem_req_addr),
                .mem_rsp_valid (mem_rsp_valid),
                .mem_rsp_data  (mem_rsp_data),
                .flush_valid   (flush_valid),
                .flush_ready   (flush_ready),
                .index         (index),
                .rd_en         (rd_en),
                .wr_en         (wr_en),
                .wr_data       (wr_data),
                .tag_wr        (tag_wr),
                .tag_wdata     (tag_wdata),
                .flush         (flush),
                .rd_data       (rd_data),
                .rd_tag        (rd_tag),
                .rd_valid      (rd_valid)
        );

        icache_data_ram u_data_ram (
                .clk     (clk),
                .index   (index),
                .rd_en   (rd_en),
                .wr_en   (wr_en),
                .wr_data (wr_data),
                .rd_data (rd_data)
        );

        icache_tag_ram u_tag_ram (
                .clk       (clk),
                .arst_n    (arst_n),
                .index     (index),
                .rd_en     (rd_en),
                .tag_wr    (tag_wr),
                .tag_wdata (tag_wdata),
                .flush     (flush),
                .rd_tag    (rd_tag),
                .rd_valid  (rd_valid)
        );

endmodule

//--- bench/icache_mem_model.sv
// --------------------------------------------------------------------------
// memory responder for the instruction cache testbench
// takes a line request after 0-3 cycles and returns its two words, upper
// word first, 1-4 cycles after that; word w holds w * 0x9E3779B1 ^ 0x5A5A0000
// --------------------------------------------------------------------------

`include "icache_consts.svh"

module icache_mem_model (
        input  logic                  clk,
        input  logic                  arst_n,
        input  logic                  mem_req_valid,
        output logic                  mem_req_ready,
        input  logic [`IC_ADDR_W-1:0] mem_req_addr,
        output logic                  mem_rsp_valid,
        output icache_pkg::ic_word_t  mem_rsp_data
);
        timeunit 1ns;
        timeprecision 1ps;

        // word address of the upper word of the requested line
        logic [31:0] word_addr;

        // content depends on every bit of the word address
        function automatic logic [31:0] word_at(input logic [31:0] w);
                return (w * 32'h9E37_79B1) ^ 32'h5A5A_0000;
        endfunction

        // all outputs move on the falling edge
        initial begin
                mem_req_ready = 1'b0;
                mem_rsp_valid = 1'b0;
                mem_rsp_data  = '0;
                forever begin
                        @(negedge clk);
                        if (arst_n && mem_req_valid) begin
                                word_addr = 32'(mem_req_addr >> 2);
                                repeat ($urandom_range(3, 0)) @(negedge clk);
                                mem_req_ready = 1'b1;
                                @(negedge clk);
                                mem_req_ready = 1'b0;
                                // first beat lands 1-4 cycles after the accept edge
                                repeat ($urandom_range(3, 0)) @(negedge clk);
                                mem_rsp_valid = 1'b1;
                                mem_rsp_data  = word_at(word_addr);
                                @(negedge clk);
                                mem_rsp_data  = word_at(word_addr + 32'd1);
                                @(negedge clk);
                                mem_rsp_valid = 1'b0;
                        end
                end
        end

endmodule

//--- bench/icache_tb.sv
// --------------------------------------------------------------------------
// testbench for the instruction cache
// drives fetches and flushes on the falling edge, keeps a reference copy of
// the tags and valid bits, and checks the DUT with concurrent assertions
// --------------------------------------------------------------------------

`include "icache_consts.svh"

module icache_tb;
        timeunit 1ns;
        timeprecision 1ps;

        // 400 random fetches at about 40 cycles worst case plus the directed phases
        localparam int MAX_CYCLES = 20_000;
        localparam int OFF_W      = `IC_OFFSET_W;

        logic clk, arst_n, req_valid, req_ready, rsp_valid, rsp_ready;
        logic mem_req_valid, mem_req_ready, mem_rsp_valid, flush_valid, flush_ready;
        logic [`IC_ADDR_W-1:0] req_addr, mem_req_addr;
        icache_pkg::ic_dword_t rsp_data;
        icache_pkg::ic_word_t  mem_rsp_data;

        // reference copy of the tag array
        icache_pkg::ic_tag_t ref_tag [0:(1<<`IC_INDEX_W)-1];
        logic [(1<<`IC_INDEX_W)-1:0] ref_valid;
        // fetch in flight and what the model expects of it
        logic [`IC_ADDR_W-1:0] pend_addr;
        logic pend_hit, req_acc, model_hit;
        icache_pkg::ic_index_t req_idx, pend_idx;
        int mem_count, rsp_total, mem_total, flush_total;
        int errors = 0;
        int cycles = 0;
        int tests = 0;
        int phase_start = 0;
        // few indices so that tags collide often
        int idx_pool [4] = '{0, 5, 6, 127};

        icache_top dut (.*);
        icache_mem_model u_mem (.*);

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        assign req_acc   = req_valid && req_ready && !flush_valid;
        assign req_idx   = req_addr[OFF_W +: `IC_INDEX_W];
        assign pend_idx  = pend_addr[OFF_W +: `IC_INDEX_W];
        assign model_hit = ref_valid[req_idx] &&
                           ref_tag[req_idx] == req_addr[`IC_ADDR_W-1 -: `IC_TAG_W];

        function automatic void note_error(input string msg);
                errors++;
                $display("Fail %0t: %s", $time, msg);
        endfunction

        function automatic logic [31:0] expected_word(input logic [31:0] w);
                return (w * 32'h9E37_79B1) ^ 32'h5A5A_0000;
        endfunction

        // upper word of the line is the even word address
        function automatic icache_pkg::ic_dword_t expected_line(input logic [`IC_ADDR_W-1:0] a);
                logic [31:0] w;
                w = 32'(a >> OFF_W) << 1;
                return {expected_word(w), expected_word(w + 32'd1)};
        endfunction

        function automatic logic [`IC_ADDR_W-1:0] make_addr(input int tag, input int idx,
                                                            input int off);
                return {icache_pkg::ic_tag_t'(tag), icache_pkg::ic_index_t'(idx), OFF_W'(off)};
        endfunction

        // model follows every response and flush handshake
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        ref_valid   <= '0;
                        mem_count   <= 0;
                        rsp_total   <= 0;
                        mem_total   <= 0;
                        flush_total <= 0;
                end else begin
                        if (flush_valid && flush_ready) begin
                                ref_valid   <= '0;
                                flush_total <= flush_total + 1;
                        end
                        if (req_acc) begin
                                mem_count <= 0;
                        end else if (mem_req_valid && mem_req_ready) begin
                                mem_count <= mem_count + 1;
                                mem_total <= mem_total + 1;
                        end
                        if (rsp_valid && rsp_ready) begin
                                ref_valid[pend_idx] <= 1'b1;
                                rsp_total           <= rsp_total + 1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (req_acc) begin
                        pend_addr <= req_addr;
                        pend_hit  <= model_hit;
                end
                if (rsp_valid && rsp_ready) begin
                        ref_tag[pend_idx] <= pend_addr[`IC_ADDR_W-1 -: `IC_TAG_W];
                end
        end

        assert property (@(posedge clk) !arst_n |-> !req_ready && !rsp_valid && !mem_req_valid)
                else note_error("outputs active during reset");
        assert property (@(posedge clk) $rose(arst_n) |-> !rsp_valid && !mem_req_valid)
                else note_error("outputs active right after reset");
        assert property (@(posedge clk) $rose(arst_n) |=> req_ready)
                else note_error("req_ready low in the first cycle after reset");
        // a hit answers in the cycle after acceptance and a miss never does
        assert property (@(posedge clk) disable iff (!arst_n) req_acc |=> rsp_valid == pend_hit)
                else note_error("lookup result differs from the reference tags");
        assert property (@(posedge clk) disable iff (!arst_n)
                        rsp_valid |-> rsp_data == expected_line(pend_addr))
                else note_error("response data differs from the memory line");
        assert property (@(posedge clk) disable iff (!arst_n)
                        rsp_valid && rsp_ready |-> mem_count == (pend_hit ? 0 : 1))
                else note_error("wrong number of memory requests for this fetch");
        assert property (@(posedge clk) disable iff (!arst_n) mem_req_valid && mem_req_ready
                        |-> mem_req_addr == ((pend_addr >> OFF_W) << OFF_W))
                else note_error("memory request address not the line of the fetch");
        assert property (@(posedge clk) disable iff (!arst_n) rsp_valid && !rsp_ready
                        |=> rsp_valid && $stable(rsp_data) && !req_ready)
                else note_error("response moved under back-pressure");
        // flush is offered exactly when a fetch would be taken
        assert property (@(posedge clk) disable iff (!arst_n) flush_ready == req_ready)
                else note_error("flush_ready differs from req_ready");
        assert property (@(posedge clk) disable iff (!arst_n)
                        flush_valid && flush_ready |=> req_ready)
                else note_error("flush handshake dropped req_ready");

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles == MAX_CYCLES) begin
                        $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
                        $display("FAIL: see errors above");
                        $finish;
                end
        end

        // advance to the next falling edge with rsp_ready high about 70 percent of the time
        task automatic drive_cycle();
                @(negedge clk);
                rsp_ready = ($urandom_range(99, 0) < 70);
        endtask

        task automatic fetch(input logic [`IC_ADDR_W-1:0] addr);
                drive_cycle();
                req_valid = 1'b1;
                req_addr  = addr;
                while (!req_ready) drive_cycle();
                drive_cycle();
                req_valid = 1'b0;
                while (!(rsp_valid && rsp_ready)) drive_cycle();
        endtask

        task automatic flush_cache();
                drive_cycle();
                flush_valid = 1'b1;
                while (!flush_ready) drive_cycle();
                drive_cycle();
                flush_valid = 1'b0;
        endtask

        task automatic finish_phase(input string name);
                drive_cycle();
                tests++;
                $display("test %0d %s done, %0d errors", tests, name, errors - phase_start);
                phase_start = errors;
        endtask

        initial begin
                void'($urandom(94126));
                arst_n      = 1'b0;
                req_valid   = 1'b0;
                req_addr    = '0;
                rsp_ready   = 1'b0;
                flush_valid = 1'b0;
                repeat (2) @(posedge clk);
                @(negedge clk);
                arst_n = 1'b1;
                repeat (2) drive_cycle();
                finish_phase("reset check");
                // cold misses then hits in the same lines
                fetch(make_addr(1, 5, 0));
                fetch(make_addr(1, 5, 3));
                fetch(make_addr(1, 6, 0));
                fetch(make_addr(1, 6, 7));
                finish_phase("hit and miss");
                // tag 2 takes line 5 from tag 1 and back again
                fetch(make_addr(2, 5, 1));
                fetch(make_addr(1, 5, 4));
                fetch(make_addr(2, 5, 2));
                fetch(make_addr(1, 5, 7));
                finish_phase("conflict eviction");
                flush_cache();
                fetch(make_addr(1, 5, 0));
                fetch(make_addr(1, 6, 2));
                finish_phase("flush");
                for (int i = 0; i < 400; i++) begin
                        if ($urandom_range(24, 0) == 0) begin
                                flush_cache();
                        end
                        fetch(make_addr($urandom_range(3, 0), idx_pool[2'($urandom_range(3, 0))],
                                        $urandom_range(7, 0)));
                end
                finish_phase("random requests");
                $display("%0d tests, %0d responses, %0d memory requests, %0d flushes, %0d errors",
                         tests, rsp_total, mem_total, flush_total, errors);
                if (errors == 0) begin
                        $display("PASS: all tests");
                end else begin
                        $display("FAIL: see errors above");
                end
                $finish;
        end

endmodule

//--- tb.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_data_ram.sv
rtl/icache_tag_ram.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
bench/icache_mem_model.sv
bench/icache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the instruction cache testbench with Verilator and run it
# the result is read from the simulation log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -sv --timescale 1ns/1ps \
        -f tb.f --top-module icache_tb -Mdir obj_dir -o Vicache_tb

./obj_dir/Vicache_tb 2>&1 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
        echo "simulation reported failures, see sim.log"
        exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
        echo "simulation ended without a result, see sim.log"
        exit 1
fi
echo "simulation passed"
